//--- hdl/riscv_pkg.sv
// RISC-V ISA encoding package
// Opcodes, funct3/funct7 codes and field widths of the RV32 integer ALU groups
package riscv_pkg;

    // ------------------------------------------------------------------
    // Field widths
    // ------------------------------------------------------------------
    localparam int unsigned INSTR_W    = 32;
    localparam int unsigned OPCODE_W   = 7;
    localparam int unsigned FUNCT3_W   = 3;
    localparam int unsigned FUNCT7_W   = 7;
    localparam int unsigned REG_ADDR_W = 5;

    typedef logic [INSTR_W-1:0]    instr_t;
    typedef logic [REG_ADDR_W-1:0] reg_addr_t;

    // Major opcodes
    localparam logic [OPCODE_W-1:0] OPCODE_OP     = 7'b0110011;
    localparam logic [OPCODE_W-1:0] OPCODE_OP_IMM = 7'b0010011;
    localparam logic [OPCODE_W-1:0] OPCODE_LUI    = 7'b0110111;

    // funct3 for OP and OP-IMM
    localparam logic [FUNCT3_W-1:0] F3_ADD_SUB = 3'b000;
    localparam logic [FUNCT3_W-1:0] F3_SLL     = 3'b001;
    localparam logic [FUNCT3_W-1:0] F3_SLT     = 3'b010;
    localparam logic [FUNCT3_W-1:0] F3_SLTU    = 3'b011;
    localparam logic [FUNCT3_W-1:0] F3_XOR     = 3'b100;
    localparam logic [FUNCT3_W-1:0] F3_SR      = 3'b101;
    localparam logic [FUNCT3_W-1:0] F3_OR      = 3'b110;
    localparam logic [FUNCT3_W-1:0] F3_AND     = 3'b111;

    // Selects SUB and SRA/SRAI
    localparam logic [FUNCT7_W-1:0] F7_ALT = 7'b0100000;

endpackage

//--- hdl/core_pkg.sv
// Core microarchitecture package
// Data word, ALU operations, exceptions and the records passed between stages
package core_pkg;

    localparam int unsigned XLEN = 32;

    typedef logic [XLEN-1:0] word_t;

    typedef enum logic [3:0] {
        ALU_ADD,
        ALU_SUB,
        ALU_AND,
        ALU_OR,
        ALU_XOR,
        ALU_SLL,
        ALU_SRL,
        ALU_SRA,
        ALU_SLT,
        ALU_SLTU,
        ALU_LUI
    } alu_op_t;

    // ------------------------------------------------------------------
    // Exceptions
    // ------------------------------------------------------------------
    typedef logic [3:0] exc_cause_t;

    localparam exc_cause_t EXC_ILLEGAL_INSTR = 4'd2;

    typedef struct packed {
        logic       valid;
        exc_cause_t cause;
        word_t      tval;
    } exception_t;

    // ------------------------------------------------------------------
    // Stage records
    // ------------------------------------------------------------------
    // Decoded instruction, the scoreboard entry
    typedef struct packed {
        alu_op_t              op;
        riscv_pkg::reg_addr_t rs1;
        riscv_pkg::reg_addr_t rs2;
        riscv_pkg::reg_addr_t rd;
        word_t                imm;
        logic                 use_imm;
        logic                 we;
        exception_t           ex;
        riscv_pkg::instr_t    instr;
    } sb_entry_t;

    // Issued operation with operands read
    typedef struct packed {
        alu_op_t              op;
        word_t                operand_a;
        word_t                operand_b;
        riscv_pkg::reg_addr_t rd;
        logic                 we;
        exception_t           ex;
    } ex_req_t;

    // ALU result on its way to commit
    typedef struct packed {
        riscv_pkg::reg_addr_t rd;
        logic                 we;
        word_t                result;
        exception_t           ex;
    } wb_t;

endpackage

//--- hdl/stage_if.sv
// Pipeline stage interface
// Valid/ready handshake carrying one payload record per transfer
interface stage_if #(
    parameter type payload_t = logic
) ();

    logic     valid;
    logic     ready;
    payload_t payload;

    // Producer side holds valid and payload stable until ready
    modport src (
        output valid,
        output payload,
        input  ready
    );

    modport dst (
        input  valid,
        input  payload,
        output ready
    );

endinterface

//--- hdl/id_stage.sv
// Instruction decode stage
// Turns an RV32 ALU instruction into a scoreboard entry, flags illegal encodings
module id_stage (
    input  logic              clk_i,
    input  logic              rst_ni,
    input  logic              instr_valid_i,
    input  riscv_pkg::instr_t instr_i,
    output logic              instr_ready_o,
    stage_if.src              dec_o
);
    import core_pkg::*;
    import riscv_pkg::*;

    logic [OPCODE_W-1:0] opcode;
    logic [FUNCT3_W-1:0] funct3;
    logic [FUNCT7_W-1:0] funct7;
    logic                alt;
    logic                illegal;
    logic                accept;
    logic                valid_q;
    sb_entry_t           dec;
    sb_entry_t           entry_q;

    assign opcode = instr_i[6:0];
    assign funct3 = instr_i[14:12];
    assign funct7 = instr_i[31:25];
    assign alt    = (funct7 == F7_ALT);

    // ------------------------------------------------------------------
    // Decoder
    // ------------------------------------------------------------------
    always_comb begin
        dec         = '0;
        illegal     = 1'b0;
        dec.instr   = instr_i;
        dec.rd      = instr_i[11:7];
        dec.rs1     = instr_i[19:15];
        dec.rs2     = instr_i[24:20];
        // I-type immediate, shifts only look at the low 5 bits
        dec.imm     = {{20{instr_i[31]}}, instr_i[31:20]};
        dec.we      = 1'b1;

        unique case (opcode)
            OPCODE_OP: begin
                if (funct7 != '0 && !(alt && (funct3 == F3_ADD_SUB || funct3 == F3_SR))) begin
                    illegal = 1'b1;
                end
                case (funct3)
                    F3_ADD_SUB: dec.op = alt ? ALU_SUB : ALU_ADD;
                    F3_SLL:     dec.op = ALU_SLL;
                    F3_SLT:     dec.op = ALU_SLT;
                    F3_SLTU:    dec.op = ALU_SLTU;
                    F3_XOR:     dec.op = ALU_XOR;
                    F3_SR:      dec.op = alt ? ALU_SRA : ALU_SRL;
                    F3_OR:      dec.op = ALU_OR;
                    F3_AND:     dec.op = ALU_AND;
                    default:    illegal = 1'b1;
                endcase
            end
            OPCODE_OP_IMM: begin
                dec.use_imm = 1'b1;
                dec.rs2     = '0;
                case (funct3)
                    F3_ADD_SUB: dec.op = ALU_ADD;
                    F3_SLL: begin
                        dec.op  = ALU_SLL;
                        illegal = (funct7 != '0);
                    end
                    F3_SLT:     dec.op = ALU_SLT;
                    F3_SLTU:    dec.op = ALU_SLTU;
                    F3_XOR:     dec.op = ALU_XOR;
                    F3_SR: begin
                        dec.op  = alt ? ALU_SRA : ALU_SRL;
                        illegal = (funct7 != '0) && !alt;
                    end
                    F3_OR:      dec.op = ALU_OR;
                    F3_AND:     dec.op = ALU_AND;
                    default:    illegal = 1'b1;
                endcase
            end
            OPCODE_LUI: begin
                dec.op      = ALU_LUI;
                dec.use_imm = 1'b1;
                dec.rs1     = '0;
                dec.rs2     = '0;
                dec.imm     = {instr_i[31:12], 12'b0};
            end
            default: illegal = 1'b1;
        endcase

        // No register access at all, only the exception travels on
        if (illegal) begin
            dec.op       = ALU_ADD;
            dec.rs1      = '0;
            dec.rs2      = '0;
            dec.rd       = '0;
            dec.use_imm  = 1'b0;
            dec.we       = 1'b0;
            dec.ex.valid = 1'b1;
            dec.ex.cause = EXC_ILLEGAL_INSTR;
            dec.ex.tval  = instr_i;
        end
    end

    // ------------------------------------------------------------------
    // Output register
    // ------------------------------------------------------------------
    assign instr_ready_o = ~valid_q | dec_o.ready;
    assign accept        = instr_valid_i & instr_ready_o;

    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            valid_q <= 1'b0;
        end else if (accept) begin
            valid_q <= 1'b1;
        end else if (dec_o.ready) begin
            valid_q <= 1'b0;
        end
    end

    always_ff @(posedge clk_i) begin
        if (accept) begin
            entry_q <= dec;
        end
    end

    assign dec_o.valid   = valid_q;
    assign dec_o.payload = entry_q;

endmodule

//--- hdl/issue_stage.sv
// Issue stage
// Register file with busy bits, stalls on hazards and reads the operands
module issue_stage (
    input  logic                 clk_i,
    input  logic                 rst_ni,
    stage_if.dst                 dec_i,
    stage_if.src                 iss_o,
    input  logic                 rf_we_i,
    input  riscv_pkg::reg_addr_t rf_waddr_i,
    input  core_pkg::word_t      rf_wdata_i
);
    import core_pkg::*;

    localparam int unsigned NR_REGS = 32;

    word_t              regs_q [NR_REGS];
    logic [NR_REGS-1:0] busy_q;
    sb_entry_t          entry;
    ex_req_t            req_d;
    ex_req_t            req_q;
    logic               valid_q;
    logic               hazard;
    logic               issue;
    word_t              rs1_data;
    word_t              rs2_data;

    assign entry = dec_i.payload;

    // ------------------------------------------------------------------
    // Hazard check
    // ------------------------------------------------------------------
    // Also wait while rd is in flight, an older writer would otherwise
    // clear the busy bit of a younger one at commit
    assign hazard = dec_i.valid &
                    (busy_q[entry.rs1] | busy_q[entry.rs2] | (entry.we & busy_q[entry.rd]));

    assign dec_i.ready = (~valid_q | iss_o.ready) & ~hazard;
    assign issue       = dec_i.valid & dec_i.ready;

    // ------------------------------------------------------------------
    // Register file
    // ------------------------------------------------------------------
    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            for (int i = 0; i < NR_REGS; i++) begin
                regs_q[i] <= '0;
            end
        end else if (rf_we_i) begin
            regs_q[rf_waddr_i] <= rf_wdata_i;
        end
    end

    // x0 is hardwired to zero
    assign rs1_data = (entry.rs1 == '0) ? '0 : regs_q[entry.rs1];
    assign rs2_data = (entry.rs2 == '0) ? '0 : regs_q[entry.rs2];

    // Set on issue wins over the clear from commit
    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            busy_q <= '0;
        end else begin
            if (rf_we_i) begin
                busy_q[rf_waddr_i] <= 1'b0;
            end
            if (issue && entry.we && entry.rd != '0) begin
                busy_q[entry.rd] <= 1'b1;
            end
        end
    end

    // ------------------------------------------------------------------
    // Issue register
    // ------------------------------------------------------------------
    always_comb begin
        req_d.op        = entry.op;
        req_d.operand_a = rs1_data;
        req_d.operand_b = entry.use_imm ? entry.imm : rs2_data;
        req_d.rd        = entry.rd;
        req_d.we        = entry.we;
        req_d.ex        = entry.ex;
    end

    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            valid_q <= 1'b0;
        end else if (issue) begin
            valid_q <= 1'b1;
        end else if (iss_o.ready) begin
            valid_q <= 1'b0;
        end
    end

    always_ff @(posedge clk_i) begin
        if (issue) begin
            req_q <= req_d;
        end
    end

    assign iss_o.valid   = valid_q;
    assign iss_o.payload = req_q;

endmodule

//--- hdl/ex_stage.sv
// Execute stage
// Single RV32 ALU with a registered result
module ex_stage (
    input  logic clk_i,
    input  logic rst_ni,
    stage_if.dst iss_i,
    stage_if.src wb_o
);
    import core_pkg::*;

    ex_req_t    req;
    word_t      a;
    word_t      b;
    logic [4:0] shamt;
    word_t      alu_res;
    wb_t        wb_d;
    wb_t        wb_q;
    logic       valid_q;
    logic       accept;

    assign req   = iss_i.payload;
    assign a     = req.operand_a;
    assign b     = req.operand_b;
    assign shamt = b[4:0];

    always_comb begin
        unique case (req.op)
            ALU_ADD:  alu_res = a + b;
            ALU_SUB:  alu_res = a - b;
            ALU_AND:  alu_res = a & b;
            ALU_OR:   alu_res = a | b;
            ALU_XOR:  alu_res = a ^ b;
            ALU_SLL:  alu_res = a << shamt;
            ALU_SRL:  alu_res = a >> shamt;
            ALU_SRA:  alu_res = word_t'($signed(a) >>> shamt);
            ALU_SLT:  alu_res = {{(XLEN-1){1'b0}}, $signed(a) < $signed(b)};
            ALU_SLTU: alu_res = {{(XLEN-1){1'b0}}, a < b};
            ALU_LUI:  alu_res = b;
            default:  alu_res = '0;
        endcase
    end

    // Excepting instructions carry no result
    assign wb_d.rd     = req.rd;
    assign wb_d.we     = req.we;
    assign wb_d.result = req.ex.valid ? '0 : alu_res;
    assign wb_d.ex     = req.ex;

    assign iss_i.ready = ~valid_q | wb_o.ready;
    assign accept      = iss_i.valid & iss_i.ready;

    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            valid_q <= 1'b0;
        end else if (accept) begin
            valid_q <= 1'b1;
        end else if (wb_o.ready) begin
            valid_q <= 1'b0;
        end
    end

    always_ff @(posedge clk_i) begin
        if (accept) begin
            wb_q <= wb_d;
        end
    end

    assign wb_o.valid   = valid_q;
    assign wb_o.payload = wb_q;

endmodule

//--- hdl/commit_stage.sv
// Commit stage
// In-order register writeback and the retirement report
module commit_stage (
    input  logic                  clk_i,
    input  logic                  rst_ni,
    stage_if.dst                  wb_i,
    output logic                  rf_we_o,
    output riscv_pkg::reg_addr_t  rf_waddr_o,
    output core_pkg::word_t       rf_wdata_o,
    output logic                  commit_valid_o,
    output riscv_pkg::reg_addr_t  commit_rd_o,
    output logic                  commit_we_o,
    output core_pkg::word_t       commit_wdata_o,
    output logic                  commit_exc_o,
    output core_pkg::exc_cause_t  commit_cause_o
);
    import core_pkg::*;

    wb_t wb;

    assign wb = wb_i.payload;

    // Commit is never stalled
    assign wb_i.ready = 1'b1;

    // Register file write, x0 and faulting instructions leave it untouched
    assign rf_we_o    = wb_i.valid & wb.we & ~wb.ex.valid & (wb.rd != '0);
    assign rf_waddr_o = wb.rd;
    assign rf_wdata_o = wb.result;

    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            commit_valid_o <= 1'b0;
        end else begin
            commit_valid_o <= wb_i.valid;
        end
    end

    // Report payload, wdata shows tval on an exception
    always_ff @(posedge clk_i) begin
        if (wb_i.valid) begin
            commit_rd_o    <= wb.rd;
            commit_we_o    <= wb.we & ~wb.ex.valid;
            commit_wdata_o <= wb.ex.valid ? wb.ex.tval : wb.result;
            commit_exc_o   <= wb.ex.valid;
            commit_cause_o <= wb.ex.cause;
        end
    end

endmodule

//--- hdl/mini_core.sv
// Mini core top level
// In-order decode, issue, execute and commit chain for RV32 ALU instructions
module mini_core (
    input  logic                 clk_i,
    input  logic                 rst_ni,
    // Instruction stream
    input  logic                 instr_valid_i,
    input  riscv_pkg::instr_t    instr_i,
    output logic                 instr_ready_o,
    // Retirement report
    output logic                 commit_valid_o,
    output riscv_pkg::reg_addr_t commit_rd_o,
    output logic                 commit_we_o,
    output core_pkg::word_t      commit_wdata_o,
    output logic                 commit_exc_o,
    output core_pkg::exc_cause_t commit_cause_o
);
    import core_pkg::*;
    import riscv_pkg::*;

    // ------------------------------------------------------------------
    // Stage links
    // ------------------------------------------------------------------
    stage_if #(.payload_t(sb_entry_t)) dec_if ();
    stage_if #(.payload_t(ex_req_t))   iss_if ();
    stage_if #(.payload_t(wb_t))       wb_if ();

    // Commit to register file
    logic      rf_we;
    reg_addr_t rf_waddr;
    word_t     rf_wdata;

    id_stage u_id_stage (
        .clk_i         ( clk_i         ),
        .rst_ni        ( rst_ni        ),
        .instr_valid_i ( instr_valid_i ),
        .instr_i       ( instr_i       ),
        .instr_ready_o ( instr_ready_o ),
        .dec_o         ( dec_if        )
    );

    issue_stage u_issue_stage (
        .clk_i      ( clk_i    ),
        .rst_ni     ( rst_ni   ),
        .dec_i      ( dec_if   ),
        .iss_o      ( iss_if   ),
        .rf_we_i    ( rf_we    ),
        .rf_waddr_i ( rf_waddr ),
        .rf_wdata_i ( rf_wdata )
    );

    ex_stage u_ex_stage (
        .clk_i  ( clk_i  ),
        .rst_ni ( rst_ni ),
        .iss_i  ( iss_if ),
        .wb_o   ( wb_if  )
    );

    commit_stage u_commit_stage (
        .clk_i          ( clk_i          ),
        .rst_ni         ( rst_ni         ),
        .wb_i           ( wb_if          ),
        .rf_we_o        ( rf_we          ),
        .rf_waddr_o     ( rf_waddr       ),
        .rf_wdata_o     ( rf_wdata       ),
        .commit_valid_o ( commit_valid_o ),
        .commit_rd_o    ( commit_rd_o    ),
        .commit_we_o    ( commit_we_o    ),
        .commit_wdata_o ( commit_wdata_o ),
        .commit_exc_o   ( commit_exc_o   ),
        .commit_cause_o ( commit_cause_o )
    );

endmodule

//--- tb/tb_mini_core.sv
// Mini core testbench
// Streams instructions from the stimulus file and checks every retirement in order
module tb_mini_core;
    timeunit 1ns;
    timeprecision 100ps;

    import core_pkg::*;
    import riscv_pkg::*;

    localparam int          RESET_CYCLES = 8;
    localparam int          MAX_ENTRIES  = 64;
    localparam int          ENTRY_WORDS  = 6;
    localparam int          STALL_LIMIT  = 50;
    localparam int          RETIRE_LIMIT = 100;
    localparam logic [31:0] LFSR_SEED    = 32'ha689;

    logic       clk_i;
    logic       rst_ni;
    logic       instr_valid_i;
    instr_t     instr_i;
    logic       instr_ready_o;
    logic       commit_valid_o;
    reg_addr_t  commit_rd_o;
    logic       commit_we_o;
    word_t      commit_wdata_o;
    logic       commit_exc_o;
    exc_cause_t commit_cause_o;

    // Word 0 holds the entry count and each entry takes six words
    logic [31:0] stim_mem [1 + ENTRY_WORDS*MAX_ENTRIES];
    logic [31:0] lfsr_state;

    mini_core u_mini_core (
        .clk_i          ( clk_i          ),
        .rst_ni         ( rst_ni         ),
        .instr_valid_i  ( instr_valid_i  ),
        .instr_i        ( instr_i        ),
        .instr_ready_o  ( instr_ready_o  ),
        .commit_valid_o ( commit_valid_o ),
        .commit_rd_o    ( commit_rd_o    ),
        .commit_we_o    ( commit_we_o    ),
        .commit_wdata_o ( commit_wdata_o ),
        .commit_exc_o   ( commit_exc_o   ),
        .commit_cause_o ( commit_cause_o )
    );

    always #5 clk_i = ~clk_i;

    // ------------------------------------------------------------------
    // Failure reporting
    // ------------------------------------------------------------------
    task automatic end_in_failure();
        $display("sim failed");
        $fatal(1);
    endtask

    task automatic report_mismatch(input string msg);
        $display("Mismatch at %0t ns: %s", $time, msg);
        end_in_failure();
    endtask

    task automatic report_failure(input string msg);
        $display("Error at %0t ns: %s", $time, msg);
        end_in_failure();
    endtask

    // ------------------------------------------------------------------
    // Random idle gaps
    // ------------------------------------------------------------------
    // Taps for x^32 + x^22 + x^2 + x + 1
    function automatic logic [31:0] lfsr_next(input logic [31:0] state);
        return {state[30:0], state[31] ^ state[21] ^ state[1] ^ state[0]};
    endfunction

    // Two bits give a gap of 0 to 3 cycles
    task automatic draw_gap(output int cycles);
        cycles = 0;
        repeat (2) begin
            lfsr_state = lfsr_next(lfsr_state);
            cycles     = cycles * 2 + int'(lfsr_state[0]);
        end
    endtask

    // ------------------------------------------------------------------
    // Compare tasks
    // ------------------------------------------------------------------
    task automatic check_writeback(input int idx, input reg_addr_t exp_rd,
                                   input logic exp_we, input word_t exp_wdata);
        if (commit_rd_o !== exp_rd || commit_we_o !== exp_we || commit_wdata_o !== exp_wdata) begin
            report_mismatch($sformatf(
                "entry %0d got rd %0d we %0b wdata %08h, want rd %0d we %0b wdata %08h",
                idx, commit_rd_o, commit_we_o, commit_wdata_o, exp_rd, exp_we, exp_wdata));
        end
    endtask

    task automatic check_exception(input int idx, input logic exp_exc,
                                   input exc_cause_t exp_cause);
        if (commit_exc_o !== exp_exc || (exp_exc && commit_cause_o !== exp_cause)) begin
            report_mismatch($sformatf("entry %0d got exc %0b cause %0d, want exc %0b cause %0d",
                idx, commit_exc_o, commit_cause_o, exp_exc, exp_cause));
        end
    endtask

    // ------------------------------------------------------------------
    // Reset, driver and retirement monitor
    // ------------------------------------------------------------------
    task automatic apply_reset();
        instr_valid_i = 1'b0;
        instr_i       = '0;
        rst_ni        = 1'b0;
        repeat (RESET_CYCLES) @(negedge clk_i);
        rst_ni = 1'b1;
        @(negedge clk_i);
        if (commit_valid_o !== 1'b0 || instr_ready_o !== 1'b1) begin
            report_mismatch("commit_valid_o must be low and instr_ready_o high after reset");
        end
    endtask

    // Runs from a falling edge to the falling edge after the handshake
    task automatic send_instr(input instr_t word);
        int waited;
        waited        = 0;
        instr_valid_i = 1'b1;
        instr_i       = word;
        // instr_ready_o depends only on stage registers
        while (instr_ready_o !== 1'b1) begin
            waited++;
            if (waited > STALL_LIMIT) begin
                report_failure("instruction input stayed stalled too long");
            end
            @(negedge clk_i);
        end
        @(negedge clk_i);
        instr_valid_i = 1'b0;
    endtask

    task automatic drive_stream(input int count, input logic with_gaps);
        int gap;
        for (int idx = 0; idx < count; idx++) begin
            gap = 0;
            if (with_gaps) begin
                draw_gap(gap);
            end
            repeat (gap) @(negedge clk_i);
            send_instr(stim_mem[1 + ENTRY_WORDS*idx]);
        end
    endtask

    task automatic check_retirements(input int count);
        int waited;
        int base;
        for (int idx = 0; idx < count; idx++) begin
            waited = 0;
            @(negedge clk_i);
            while (commit_valid_o !== 1'b1) begin
                waited++;
                if (waited > RETIRE_LIMIT) begin
                    report_failure($sformatf("entry %0d never retired", idx));
                end
                @(negedge clk_i);
            end
            base = 1 + ENTRY_WORDS*idx;
            check_writeback(idx, stim_mem[base+1][4:0], stim_mem[base+2][0], stim_mem[base+3]);
            check_exception(idx, stim_mem[base+4][0], stim_mem[base+5][3:0]);
        end
    endtask

    // Nothing may retire once the expected sequence is done
    task automatic check_idle();
        repeat (8) begin
            @(negedge clk_i);
            if (commit_valid_o !== 1'b0) begin
                report_mismatch("retirement beyond the end of the stimulus");
            end
        end
    endtask

    initial begin
        int count;
        clk_i         = 1'b0;
        rst_ni        = 1'b0;
        instr_valid_i = 1'b0;
        instr_i       = '0;
        lfsr_state    = LFSR_SEED;
        $readmemh("tb/core_stimulus.txt", stim_mem);
        count = int'(stim_mem[0]);
        if (count < 1 || count > MAX_ENTRIES) begin
            report_failure("stimulus file holds no valid entry count");
        end
        // Pass 0 runs back to back and pass 1 with random gaps
        for (int pass = 0; pass < 2; pass++) begin
            apply_reset();
            fork
                drive_stream(count, pass == 1);
                check_retirements(count);
            join
            check_idle();
        end
        $display("sim passed");
        $finish;
    end

endmodule

//--- tb/core_stimulus.txt
// Columns, all hex: instruction, rd, we, wdata, exc, cause
// The first value is the number of entries that follow
1b
00500093 01 1 00000005 0 0  // addi x1, x0, 5
ffd00113 02 1 fffffffd 0 0  // addi x2, x0, -3
002081b3 03 1 00000002 0 0  // add x3, x1, x2
40208233 04 1 00000008 0 0  // sub x4, x1, x2
0020f2b3 05 1 00000005 0 0  // and x5, x1, x2
0020e333 06 1 fffffffd 0 0  // or x6, x1, x2
0020c3b3 07 1 fffffff8 0 0  // xor x7, x1, x2
00409433 08 1 00000500 0 0  // sll x8, x1, x4
001154b3 09 1 07ffffff 0 0  // srl x9, x2, x1
40115533 0a 1 ffffffff 0 0  // sra x10, x2, x1
001125b3 0b 1 00000001 0 0  // slt x11, x2, x1
00113633 0c 1 00000000 0 0  // sltu x12, x2, x1
123456b7 0d 1 12345000 0 0  // lui x13, 0x12345
67868713 0e 1 12345678 0 0  // addi x14, x13, 0x678
fff74793 0f 1 edcba987 0 0  // xori x15, x14, -1
0f00e813 10 1 000000f5 0 0  // ori x16, x1, 0xf0
0ff7f893 11 1 00000087 0 0  // andi x17, x15, 0xff
00409913 12 1 00000050 0 0  // slli x18, x1, 4
0087d993 13 1 00edcba9 0 0  // srli x19, x15, 8
4087da13 14 1 ffedcba9 0 0  // srai x20, x15, 8
ffe12a93 15 1 00000001 0 0  // slti x21, x2, -2
fff0bb13 16 1 00000001 0 0  // sltiu x22, x1, -1
00708013 00 1 0000000c 0 0  // addi x0, x1, 7
00000bb3 17 1 00000000 0 0  // add x23, x0, x0
00012083 00 0 00012083 1 2  // lw x1, 0(x2), unsupported
022081b3 00 0 022081b3 1 2  // mul x3, x1, x2, unsupported
00308c33 18 1 00000007 0 0  // add x24, x1, x3

//--- all.f
hdl/riscv_pkg.sv
hdl/core_pkg.sv
hdl/stage_if.sv
hdl/id_stage.sv
hdl/issue_stage.sv
hdl/ex_stage.sv
hdl/commit_stage.sv
hdl/mini_core.sv
tb/tb_mini_core.sv

//--- Makefile
TOP := tb_mini_core

.PHONY: lint sim clean

lint:
	verilator --lint-only --timing --top-module $(TOP) -f all.f

sim:
	verilator --binary --timing --top-module $(TOP) -f all.f
	./obj_dir/V$(TOP) 2>&1 | tee sim.log
	@if grep -q "sim failed" sim.log; then echo "Simulation failed"; exit 1; fi
	@if ! grep -q "sim passed" sim.log; then echo "Simulation did not finish"; exit 1; fi

clean:
	rm -rf obj_dir sim.log
